//--- gb_sys_config.svh
`ifndef GB_SYS_CONFIG_SVH
`define GB_SYS_CONFIG_SVH

// ------------------------------------------------------------
// io register addresses
// ------------------------------------------------------------
`define GB_ADDR_JOY        16'hff00 // P1 joypad select
`define GB_ADDR_IF         16'hff0f // interrupt flags
`define GB_ADDR_KEY1       16'hff4d // speed switch
`define GB_ADDR_BOOT       16'hff50 // boot rom disable
`define GB_ADDR_SVBK       16'hff70 // wram bank
`define GB_ADDR_IE         16'hffff // interrupt enable
`define GB_ADDR_SPARE_BASE 16'hff72 // first of ff72..ff75

// ram sizes, as address widths
`define GB_WRAM_AW 15 // 8 banks of 4k
`define GB_HRAM_AW 7  // ff80..fffe

// interrupts
`define GB_IRQ_N        5
`define GB_IRQ_VEC_BASE 8'h40
`define GB_IRQ_VEC_STEP 8

// misc values
`define GB_OPEN_BUS     8'hff
`define GB_BOOT_OFF_GBC 8'h11 // colour boot rom exit value
`define GB_SVBK_RST     3'd1  // bank after reset

`endif

//--- gb_sys_pkg.sv
`default_nettype none

package gb_sys_pkg;

	// ------------------------------------------------------------
	// cpu side of the core
	// ------------------------------------------------------------
	typedef struct packed {
		logic [15:0] addr;  // cpu address
		logic [7:0]  wdata; // cpu data out
		logic        rd;    // read strobe
		logic        wr;    // write strobe
		logic        ack;   // irq acknowledge level
		logic        stop;  // STOP executed
	} cpu_bus_t;

	typedef struct packed {
		logic is_gbc;   // colour hardware
		logic gbc_game; // colour cartridge
	} mode_t;

	// event levels from the blocks outside the core
	typedef struct packed {
		logic vblank;
		logic lcdc;
		logic timer;
		logic serial;
	} irq_src_t;

	// one-hot decode result
	typedef struct packed {
		logic joy;
		logic if_r;
		logic ie;
		logic key1;
		logic svbk;
		logic boot;
		logic spare72;
		logic spare73;
		logic spare74;
		logic spare75;
		logic wram; // c000..fdff plus ff80..fffe
	} sel_t;

endpackage

`default_nettype wire

//--- gb_bus_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "gb_sys_config.svh"

module gb_bus_ctrl (
	input  wire                   clk_sys,
	input  wire                   reset_ss,
	input  gb_sys_pkg::cpu_bus_t  bus,
	input  gb_sys_pkg::mode_t     mode,
	input  wire logic             boot_rom_on,
	input  wire logic [7:0]       irq_rdata,
	input  wire logic [7:0]       ram_rdata,
	input  wire logic [7:0]       reg_rdata,
	input  wire logic [7:0]       irq_vec,
	output gb_sys_pkg::sel_t      sel,
	output logic [7:0]            cpu_di
);

	logic [15:0] a;
	logic        cgb_io;   // colour-only regs visible
	logic        sel_irq;  // byte comes from irq block
	logic        sel_reg;  // byte comes from sys regs
	logic        ram_q;    // last cycle was a ram read

	assign a = bus.addr;

	// svbk also works while the boot rom runs a mono game
	assign cgb_io = mode.is_gbc & (mode.gbc_game | boot_rom_on);

	// ------------------------------------------------------------
	// address decode
	// ------------------------------------------------------------
	always_comb begin
		sel = '0;
		sel.joy  = (a == `GB_ADDR_JOY);
		sel.if_r = (a == `GB_ADDR_IF);
		sel.ie   = (a == `GB_ADDR_IE);
		sel.boot = (a == `GB_ADDR_BOOT);
		sel.key1 = mode.is_gbc & mode.gbc_game & (a == `GB_ADDR_KEY1);
		sel.svbk = cgb_io & (a == `GB_ADDR_SVBK);
		// spare regs, ff74 only for colour games
		sel.spare72 = mode.is_gbc & (a == `GB_ADDR_SPARE_BASE);
		sel.spare73 = mode.is_gbc & (a == `GB_ADDR_SPARE_BASE + 16'd1);
		sel.spare74 = mode.is_gbc & mode.gbc_game & (a == `GB_ADDR_SPARE_BASE + 16'd2);
		sel.spare75 = mode.is_gbc & (a == `GB_ADDR_SPARE_BASE + 16'd3);
		// c000..fdff incl. echo, then high ram below ie
		sel.wram = ((a[15:14] == 2'b11) & ~&a[13:9]) |
			((&a[15:7]) & (a != `GB_ADDR_IE));
	end

	assign sel_irq = sel.if_r | sel.ie;
	assign sel_reg = sel.joy | sel.key1 | sel.svbk |
		sel.spare72 | sel.spare73 | sel.spare74 | sel.spare75;

	// ram data shows up one edge late, so the region flag follows it
	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			ram_q <= 1'b0;
		end else begin
			ram_q <= sel.wram & bus.rd; // same enable as the ram read port
		end
	end

	// ------------------------------------------------------------
	// read data mux
	// ------------------------------------------------------------
	always_comb begin
		if (bus.ack)
			cpu_di = irq_vec;       // vector fetch
		else if (sel_irq)
			cpu_di = irq_rdata;     // if / ie
		else if (sel_reg)
			cpu_di = reg_rdata;     // p1, key1, svbk, spares
		else if (ram_q)
			cpu_di = ram_rdata;     // wram, echo, hram
		else
			cpu_di = `GB_OPEN_BUS;  // nothing decoded
	end

	// decode regions never overlap
	a_sel_onehot: assert property (@(posedge clk_sys) disable iff (reset_ss)
		$onehot0(sel));

endmodule

`default_nettype wire

//--- gb_irq_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "gb_sys_config.svh"

module gb_irq_ctrl (
	input  wire                   clk_sys,
	input  wire                   reset_ss,
	input  wire                   ce,
	input  gb_sys_pkg::cpu_bus_t  bus,
	input  gb_sys_pkg::sel_t      sel,
	input  gb_sys_pkg::irq_src_t  irq_src,
	input  wire logic [3:0]       joy_din,
	output logic [7:0]            irq_rdata,
	output logic [7:0]            irq_vec,
	output logic                  irq_n
);

	logic [`GB_IRQ_N-1:0] if_q;    // pending flags
	logic [7:0]           ie_q;    // enable mask with all bits r/w
	logic [`GB_IRQ_N-1:0] pend;    // enabled and pending
	logic [`GB_IRQ_N-1:0] lowest;  // highest priority pending
	logic [3:0]           src;     // sources in flag order
	logic [3:0]           src_q;
	logic [3:0]           joy_d1;
	logic [3:0]           joy_d2;
	logic                 ack_q;
	logic [`GB_IRQ_N-1:0] if_nxt;

	// bit 0 vblank .. bit 3 serial
	assign src = {irq_src.serial, irq_src.timer, irq_src.lcdc, irq_src.vblank};

	assign pend   = if_q & ie_q[`GB_IRQ_N-1:0];
	assign lowest = pend & (~pend + 1'b1); // isolate lowest set bit
	assign irq_n  = ~|pend;

	// upper if bits read as ones
	assign irq_rdata = sel.if_r ? {3'b111, if_q} : ie_q;

	// ------------------------------------------------------------
	// vector 40/48/50/58/60
	// ------------------------------------------------------------
	always_comb begin
		irq_vec = 8'h00;
		for (int i = `GB_IRQ_N - 1; i >= 0; i--) begin
			if (pend[i])
				irq_vec = `GB_IRQ_VEC_BASE + 8'(i * `GB_IRQ_VEC_STEP);
		end
	end

	// next flags with events first and the ack clear last
	always_comb begin
		if_nxt = if_q;
		if_nxt[3:0] = if_nxt[3:0] | (src & ~src_q);   // rising edges
		if (|(~joy_d1 & joy_d2))
			if_nxt[4] = 1'b1;                          // any joypad line fell
		if (ack_q & ~bus.ack)
			if_nxt = if_nxt & ~lowest;                 // ack just ended
	end

	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			if_q   <= '0;
			ie_q   <= '0;
			src_q  <= '0;
			joy_d1 <= '0;
			joy_d2 <= '0;
			ack_q  <= 1'b0;
		end else if (ce) begin
			src_q  <= src;
			joy_d1 <= joy_din;
			joy_d2 <= joy_d1; // two stage delay on the lines
			ack_q  <= bus.ack;
			if_q   <= if_nxt;
			// cpu writes win over events
			if (bus.wr && sel.if_r)
				if_q <= bus.wdata[`GB_IRQ_N-1:0];
			if (bus.wr && sel.ie)
				ie_q <= bus.wdata;
		end
	end

	// an enabled event edge pulls the request low one edge later
	a_irq_req: assert property (@(posedge clk_sys) disable iff (reset_ss)
		(ce && |(src & ~src_q & ie_q[3:0]) && !(bus.wr && (sel.if_r || sel.ie)) &&
		!(ack_q && !bus.ack)) |=> !irq_n);

endmodule

`default_nettype wire

//--- gb_work_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "gb_sys_config.svh"

module gb_work_ram (
	input  wire                   clk_sys,
	input  wire                   reset_ss,
	input  wire                   ce,
	input  gb_sys_pkg::cpu_bus_t  bus,
	input  gb_sys_pkg::sel_t      sel,
	output logic [7:0]            ram_rdata,
	output logic [2:0]            svbk
);

	logic [7:0] wram [0:(1 << `GB_WRAM_AW) - 1];
	logic [7:0] hram [0:(1 << `GB_HRAM_AW) - 2]; // 127 bytes

	logic [`GB_WRAM_AW-1:0] wram_addr;
	logic                   is_hram;
	logic [2:0]             svbk_q;
	logic [7:0]             wram_q;
	logic [7:0]             hram_q;
	logic                   hram_rd_q; // which port to return

	assign is_hram = &bus.addr[15:7];

	// d000 half goes through the bank, echo wraps on the low 13 bits
	assign wram_addr = bus.addr[12] ? {svbk_q, bus.addr[11:0]} : {3'd0, bus.addr[11:0]};

	// bank register, 0 maps to 1
	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			svbk_q <= `GB_SVBK_RST;
		end else if (ce && bus.wr && sel.svbk) begin
			svbk_q <= (bus.wdata[2:0] == 3'd0) ? 3'd1 : bus.wdata[2:0];
		end
	end

	// ------------------------------------------------------------
	// ram ports
	// ------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (ce && bus.wr && sel.wram && !is_hram)
			wram[wram_addr] <= bus.wdata;
		if (ce && bus.wr && sel.wram && is_hram)
			hram[bus.addr[`GB_HRAM_AW-1:0]] <= bus.wdata;
		if (bus.rd) begin // read port follows the strobe
			wram_q    <= wram[wram_addr];
			hram_q    <= hram[bus.addr[`GB_HRAM_AW-1:0]];
			hram_rd_q <= is_hram;
		end
	end

	assign ram_rdata = hram_rd_q ? hram_q : wram_q;
	assign svbk      = svbk_q;

	a_svbk_nonzero: assert property (@(posedge clk_sys) disable iff (reset_ss)
		svbk_q != 3'd0);

endmodule

`default_nettype wire

//--- gb_sys_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "gb_sys_config.svh"

module gb_sys_regs (
	input  wire                   clk_sys,
	input  wire                   reset_ss,
	input  wire                   ce,
	input  gb_sys_pkg::cpu_bus_t  bus,
	input  gb_sys_pkg::sel_t      sel,
	input  gb_sys_pkg::mode_t     mode,
	input  wire logic [3:0]       joy_din,
	input  wire logic [2:0]       svbk,
	output logic [7:0]            reg_rdata,
	output logic [1:0]            joy_p54,
	output logic                  speed,
	output logic                  boot_rom_on
);

	logic [1:0] p54;
	logic       prepare;   // key1 bit 0
	logic [7:0] ff72;
	logic [7:0] ff73;
	logic [7:0] ff74;
	logic [2:0] ff75;      // bits 6..4 only
	logic       wr_ce;
	logic       boot_off;  // exit value seen

	assign wr_ce = ce & bus.wr;

	// colour boot rom writes 11, mono one any odd value
	assign boot_off = mode.is_gbc ? (bus.wdata == `GB_BOOT_OFF_GBC) : bus.wdata[0];

	// ------------------------------------------------------------
	// control registers
	// ------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			p54         <= mode.is_gbc ? 2'b11 : 2'b00;
			prepare     <= 1'b0;
			speed       <= 1'b0;
			boot_rom_on <= 1'b1;
			ff72        <= '0;
			ff73        <= '0;
			ff74        <= '0;
			ff75        <= '0;
		end else if (ce) begin
			if (wr_ce && sel.joy)     p54     <= bus.wdata[5:4];
			if (wr_ce && sel.key1)    prepare <= bus.wdata[0];
			if (wr_ce && sel.spare72) ff72    <= bus.wdata;
			if (wr_ce && sel.spare73) ff73    <= bus.wdata;
			if (wr_ce && sel.spare74) ff74    <= bus.wdata;
			if (wr_ce && sel.spare75) ff75    <= bus.wdata[6:4];
			if (wr_ce && sel.boot && boot_off)
				boot_rom_on <= 1'b0; // one way until reset
			// stop with prepare armed flips the speed
			if (mode.is_gbc && prepare && bus.stop) begin
				speed   <= ~speed;
				prepare <= 1'b0;
			end
		end
	end

	assign joy_p54 = p54;

	// read byte for own regs and svbk
	always_comb begin
		reg_rdata = `GB_OPEN_BUS;
		if (sel.joy)     reg_rdata = {2'b11, p54, joy_din};
		if (sel.key1)    reg_rdata = {speed, 6'h3f, prepare};
		if (sel.svbk)    reg_rdata = {5'h1f, svbk};
		if (sel.spare72) reg_rdata = ff72;
		if (sel.spare73) reg_rdata = ff73;
		if (sel.spare74) reg_rdata = ff74;
		if (sel.spare75) reg_rdata = {1'b1, ff75, 4'hf};
	end

endmodule

`default_nettype wire

//--- gb_sys_top.sv
`timescale 1ns/1ps
`default_nettype none

module gb_sys_top (
	input  wire                   clk_sys,
	input  wire                   reset_ss,
	input  wire                   ce,
	input  gb_sys_pkg::cpu_bus_t  bus,
	input  gb_sys_pkg::mode_t     mode,
	input  gb_sys_pkg::irq_src_t  irq_src,
	input  wire logic [3:0]       joy_din,
	output logic [7:0]            cpu_di,
	output logic                  irq_n,
	output logic [1:0]            joy_p54,
	output logic                  speed,
	output logic                  boot_rom_on
);

	gb_sys_pkg::sel_t sel;
	logic [7:0]       irq_rdata;
	logic [7:0]       irq_vec;
	logic [7:0]       ram_rdata;
	logic [7:0]       reg_rdata;
	logic [2:0]       svbk;

	gb_bus_ctrl i_gb_bus_ctrl (.clk_sys(clk_sys), .reset_ss(reset_ss), .bus(bus), .mode(mode),
		.boot_rom_on(boot_rom_on), .irq_rdata(irq_rdata), .ram_rdata(ram_rdata),
		.reg_rdata(reg_rdata), .irq_vec(irq_vec), .sel(sel), .cpu_di(cpu_di));

	gb_irq_ctrl i_gb_irq_ctrl (.clk_sys(clk_sys), .reset_ss(reset_ss), .ce(ce), .bus(bus),
		.sel(sel), .irq_src(irq_src), .joy_din(joy_din), .irq_rdata(irq_rdata),
		.irq_vec(irq_vec), .irq_n(irq_n));

	gb_work_ram i_gb_work_ram (.clk_sys(clk_sys), .reset_ss(reset_ss), .ce(ce), .bus(bus),
		.sel(sel), .ram_rdata(ram_rdata), .svbk(svbk));

	gb_sys_regs i_gb_sys_regs (.clk_sys(clk_sys), .reset_ss(reset_ss), .ce(ce), .bus(bus),
		.sel(sel), .mode(mode), .joy_din(joy_din), .svbk(svbk), .reg_rdata(reg_rdata),
		.joy_p54(joy_p54), .speed(speed), .boot_rom_on(boot_rom_on));

endmodule

`default_nettype wire

//--- tb_gb_sys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_gb_sys;

	localparam int CLK_PERIOD = 100;

	// row operations
	localparam logic [2:0] OP_IDLE = 3'd0;
	localparam logic [2:0] OP_WR   = 3'd1;
	localparam logic [2:0] OP_RD   = 3'd2;
	localparam logic [2:0] OP_SRC  = 3'd3; // one-cycle event pulse
	localparam logic [2:0] OP_JOY  = 3'd4; // joypad line level
	localparam logic [2:0] OP_ACK  = 3'd5; // ack level, held
	localparam logic [2:0] OP_STOP = 3'd6; // stop level, held

	// what the row compares
	localparam logic [2:0] CHK_NONE  = 3'd0;
	localparam logic [2:0] CHK_DI    = 3'd1;
	localparam logic [2:0] CHK_IRQN  = 3'd2;
	localparam logic [2:0] CHK_SPEED = 3'd3;
	localparam logic [2:0] CHK_BOOT  = 3'd4;
	localparam logic [2:0] CHK_P54   = 3'd5;

	// irq_src bit order is vblank, lcdc, timer, serial from msb down
	localparam logic [7:0] SRC_VBLANK = 8'h08;
	localparam logic [7:0] SRC_TIMER  = 8'h02;

	localparam gb_sys_pkg::mode_t CGB = '{is_gbc: 1'b1, gbc_game: 1'b1};

	typedef struct packed {
		logic [2:0]        op;
		logic [15:0]       addr;
		logic [7:0]        data;
		gb_sys_pkg::mode_t mode;
		logic [7:0]        exp;
		logic [2:0]        chk;
	} row_t;

	logic                  clk_sys;
	logic                  reset_ss;
	logic                  ce;
	gb_sys_pkg::cpu_bus_t  bus;
	gb_sys_pkg::mode_t     mode;
	gb_sys_pkg::irq_src_t  irq_src;
	logic [3:0]            joy_din;
	logic [7:0]            cpu_di;
	logic                  irq_n;
	logic [1:0]            joy_p54;
	logic                  speed;
	logic                  boot_rom_on;

	row_t        rows [$];
	logic [31:0] lfsr_q;
	logic        table_ready;

	gb_sys_top i_gb_sys_top (.clk_sys(clk_sys), .reset_ss(reset_ss), .ce(ce), .bus(bus),
		.mode(mode), .irq_src(irq_src), .joy_din(joy_din), .cpu_di(cpu_di), .irq_n(irq_n),
		.joy_p54(joy_p54), .speed(speed), .boot_rom_on(boot_rom_on));

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	// ------------------------------------------------------------
	// random bytes, x^32 + x^22 + x^2 + x + 1
	// ------------------------------------------------------------
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [7:0] next_rand_byte();
		logic [7:0] b;
		b = '0;
		for (int i = 0; i < 8; i++) begin
			lfsr_q = lfsr_next(lfsr_q); // one step per bit
			b = {b[6:0], lfsr_q[0]};
		end
		return b;
	endfunction

	function automatic void add_row(input logic [2:0] op, input logic [15:0] addr,
		input logic [7:0] data, input logic [2:0] chk, input logic [7:0] exp);
		rows.push_back('{op: op, addr: addr, data: data, mode: CGB, exp: exp, chk: chk});
	endfunction

	// ------------------------------------------------------------
	// compare and fail
	// ------------------------------------------------------------
	task automatic fail_run();
		$display("Result: FAILED");
		$fatal(1, "stopping at first failure");
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("ERROR at %0t: %s = %h, expected %h", $time, name, got, exp);
			fail_run();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERROR at %0t: %s = %b, expected %b", $time, name, got, exp);
			fail_run();
		end
	endtask

	task automatic check_p54(input string name, input logic [1:0] got, input logic [1:0] exp);
		if (got !== exp) begin
			$display("ERROR at %0t: %s = %b, expected %b", $time, name, got, exp);
			fail_run();
		end
	endtask

	task automatic build_table();
		logic [7:0] bank_byte [1:7];
		logic [7:0] c_byte;
		logic [7:0] h_lo;
		logic [7:0] h_hi;
		// reset state, colour hardware
		add_row(OP_RD, 16'hffff, 8'h00, CHK_DI, 8'h00);
		add_row(OP_RD, 16'hff0f, 8'h00, CHK_DI, 8'he0);
		add_row(OP_RD, 16'hff70, 8'h00, CHK_DI, 8'hf9);
		add_row(OP_RD, 16'hff4d, 8'h00, CHK_DI, 8'h7e);
		add_row(OP_RD, 16'hff00, 8'h00, CHK_DI, 8'hfb); // 11, 11, joy lines
		add_row(OP_IDLE, 16'h0000, 8'h00, CHK_IRQN, 8'h01);
		add_row(OP_IDLE, 16'h0000, 8'h00, CHK_BOOT, 8'h01);
		// wram banking
		c_byte = next_rand_byte();
		add_row(OP_WR, 16'hc123, c_byte, CHK_NONE, 8'h00);
		for (int b = 1; b < 8; b++) begin
			bank_byte[b] = next_rand_byte();
			add_row(OP_WR, 16'hff70, 8'(b), CHK_NONE, 8'h00);
			add_row(OP_WR, 16'hd123, bank_byte[b], CHK_NONE, 8'h00);
		end
		for (int b = 1; b < 8; b++) begin
			add_row(OP_WR, 16'hff70, 8'(b), CHK_NONE, 8'h00);
			add_row(OP_RD, 16'hd123, 8'h00, CHK_DI, bank_byte[b]);
		end
		add_row(OP_WR, 16'hff70, 8'h00, CHK_NONE, 8'h00); // bank 0 means 1
		add_row(OP_RD, 16'hff70, 8'h00, CHK_DI, 8'hf9);
		add_row(OP_RD, 16'hd123, 8'h00, CHK_DI, bank_byte[1]);
		add_row(OP_RD, 16'hc123, 8'h00, CHK_DI, c_byte);
		add_row(OP_RD, 16'he123, 8'h00, CHK_DI, c_byte);  // echo
		h_lo = next_rand_byte();
		h_hi = next_rand_byte();
		add_row(OP_WR, 16'hff80, h_lo, CHK_NONE, 8'h00);
		add_row(OP_WR, 16'hfffe, h_hi, CHK_NONE, 8'h00);
		add_row(OP_RD, 16'hff80, 8'h00, CHK_DI, h_lo);
		add_row(OP_RD, 16'hfffe, 8'h00, CHK_DI, h_hi);
		// ------------------------------------------------------------
		// interrupts
		// ------------------------------------------------------------
		add_row(OP_WR, 16'hffff, 8'h1f, CHK_NONE, 8'h00);
		add_row(OP_SRC, 16'h0000, SRC_TIMER, CHK_NONE, 8'h00);
		add_row(OP_SRC, 16'h0000, SRC_VBLANK, CHK_IRQN, 8'h00);
		add_row(OP_RD, 16'hff0f, 8'h00, CHK_DI, 8'he5);
		add_row(OP_ACK, 16'h0000, 8'h01, CHK_DI, 8'h40);   // vblank first
		add_row(OP_ACK, 16'h0000, 8'h00, CHK_NONE, 8'h00);
		add_row(OP_RD, 16'hff0f, 8'h00, CHK_DI, 8'he4);
		add_row(OP_ACK, 16'h0000, 8'h01, CHK_DI, 8'h50);   // then timer
		add_row(OP_ACK, 16'h0000, 8'h00, CHK_NONE, 8'h00);
		add_row(OP_RD, 16'hff0f, 8'h00, CHK_DI, 8'he0);
		add_row(OP_IDLE, 16'h0000, 8'h00, CHK_IRQN, 8'h01);
		add_row(OP_JOY, 16'h0000, 8'h03, CHK_NONE, 8'h00); // line 3 falls
		add_row(OP_RD, 16'hff0f, 8'h00, CHK_DI, 8'hf0);
		// speed switch
		add_row(OP_WR, 16'hff4d, 8'h01, CHK_NONE, 8'h00);
		add_row(OP_RD, 16'hff4d, 8'h00, CHK_DI, 8'h7f);
		add_row(OP_STOP, 16'h0000, 8'h01, CHK_SPEED, 8'h01);
		add_row(OP_STOP, 16'h0000, 8'h00, CHK_SPEED, 8'h01);
		add_row(OP_RD, 16'hff4d, 8'h00, CHK_DI, 8'hfe);
		// boot latch, spares, p1 select
		add_row(OP_WR, 16'hff50, 8'h01, CHK_BOOT, 8'h01); // mono exit value, ignored
		add_row(OP_WR, 16'hff50, 8'h11, CHK_BOOT, 8'h00);
		add_row(OP_WR, 16'hff72, 8'h5a, CHK_NONE, 8'h00);
		add_row(OP_WR, 16'hff73, 8'ha5, CHK_NONE, 8'h00);
		add_row(OP_RD, 16'hff72, 8'h00, CHK_DI, 8'h5a);
		add_row(OP_RD, 16'hff73, 8'h00, CHK_DI, 8'ha5);
		add_row(OP_WR, 16'hff75, 8'hff, CHK_NONE, 8'h00);
		add_row(OP_RD, 16'hff75, 8'h00, CHK_DI, 8'hff);
		add_row(OP_WR, 16'hff75, 8'h00, CHK_NONE, 8'h00);
		add_row(OP_RD, 16'hff75, 8'h00, CHK_DI, 8'h8f);  // only bits 6..4 stored
		add_row(OP_WR, 16'hff00, 8'h20, CHK_P54, 8'h02);
		add_row(OP_RD, 16'hff00, 8'h00, CHK_DI, 8'he3);
	endtask

	// drive at one edge, act at the next, look at the falling edge
	task automatic apply_row(input row_t r);
		@(posedge clk_sys);
		mode <= r.mode;
		case (r.op)
			OP_WR: begin
				bus.addr  <= r.addr;
				bus.wdata <= r.data;
				bus.wr    <= 1'b1;
			end
			OP_RD: begin
				bus.addr <= r.addr; // held until the next read or write
				bus.rd   <= 1'b1;
			end
			OP_SRC:  irq_src   <= r.data[3:0];
			OP_JOY:  joy_din   <= r.data[3:0];
			OP_ACK:  bus.ack   <= r.data[0];
			OP_STOP: bus.stop  <= r.data[0];
			default: ;
		endcase
		@(posedge clk_sys);
		bus.rd  <= 1'b0;
		bus.wr  <= 1'b0;
		irq_src <= '0;
		@(negedge clk_sys);
		case (r.chk)
			CHK_DI:    check_byte("cpu_di", cpu_di, r.exp);
			CHK_IRQN:  check_bit("irq_n", irq_n, r.exp[0]);
			CHK_SPEED: check_bit("speed", speed, r.exp[0]);
			CHK_BOOT:  check_bit("boot_rom_on", boot_rom_on, r.exp[0]);
			CHK_P54:   check_p54("joy_p54", joy_p54, r.exp[1:0]);
			default: ;
		endcase
	endtask

	// ------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------
	initial begin
		clk_sys     = 1'b0;
		reset_ss    = 1'b1;
		ce          = 1'b1;
		bus         = '0;
		mode        = CGB; // colour at reset, p54 comes up 11
		irq_src     = '0;
		joy_din     = 4'hb;
		lfsr_q      = 32'h1cbe4428;
		table_ready = 1'b0;
		build_table();
		table_ready = 1'b1;
		repeat (8) @(posedge clk_sys);
		reset_ss <= 1'b0;
		foreach (rows[i])
			apply_row(rows[i]);
		$display("Result: PASSED");
		$finish;
	end

	// four cycles per row plus reset
	initial begin
		int wd_cycles;
		wait (table_ready);
		wd_cycles = rows.size() * 4 + 8;
		#(wd_cycles * CLK_PERIOD);
		$display("watchdog expired before all table rows were applied");
		fail_run();
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+.
gb_sys_pkg.sv
gb_bus_ctrl.sv
gb_irq_ctrl.sv
gb_work_ram.sv
gb_sys_regs.sv
gb_sys_top.sv
tb_gb_sys.sv

//--- run_sim.sh
#!/bin/sh
# build with verilator, run, and look for the pass line
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_gb_sys \
	-o tb_gb_sys_sim && ./obj_dir/tb_gb_sys_sim | grep "Result: PASSED" \
	&& echo "simulation ok" || { echo "simulation failed"; exit 1; }
